//--- logic/router_reg_map_pkg.sv
/* Ingress register map of the packet router control block
   Word addresses, field positions and bus word types */

package router_reg_map_pkg;

    ////////////////////
    // Bus word types

    typedef logic [31:0] reg_word_t;   // One register data word
    typedef logic [15:0] byte_addr_t;  // Request byte address
    typedef logic [13:0] word_addr_t;  // Byte address over 4

    ////////////////////
    // Word addresses

    localparam word_addr_t ADDR_PARAMS0              = 14'd0; // Read only
    localparam word_addr_t ADDR_ING_PORT_ENABLE_CON  = 14'd1; // Read/write, ones after reset
    localparam word_addr_t ADDR_ING_PORT_ENABLE_STAT = 14'd2; // Read only
    localparam word_addr_t ADDR_ING_CNTR_SAMPLE_CON  = 14'd3; // Read/write
    localparam word_addr_t ADDR_ING_CNTR_READ_SEL    = 14'd4; // Read/write
    localparam word_addr_t ADDR_ING_CNTR_READ_DATA   = 14'd5; // Read only

    // Words at or above this are flagged as unknown
    localparam int NUM_REGS = 6;

    ////////////////////
    // Field positions

    // PARAMS0 fields
    localparam int PARAMS_MTU_LSB       = 0;  // 16 bit MTU in bytes
    localparam int PARAMS_NUM_PORTS_LSB = 16; // 8 bit ingress port count

    // READ_SEL fields
    localparam int SEL_PORT_LSB = 8;
    localparam int SEL_CNTR_LSB = 0;

endpackage

//--- logic/router_cntr_pkg.sv
/* Ingress counter definitions
   Counter indices within a port and the selector types */

package router_cntr_pkg;

    // Selector fields of READ_SEL
    typedef logic [7:0] port_sel_t;
    typedef logic [7:0] cntr_sel_t;

    ////////////////////
    // Counter indices

    localparam int CNTR_PKT      = 0; // Packets, from the port
    localparam int CNTR_BYTE     = 1; // Bytes, from the port
    localparam int CNTR_ERR      = 2; // Errored packets, from the port
    localparam int CNTR_FIFO_OVF = 3; // Async FIFO overflow events, counted here
    localparam int CNTR_BUF_OVF  = 4; // Buffer overflow events, counted here

    // Sampled counters kept per port
    localparam int NUM_CNTRS_PER_PORT = 5;

endpackage

//--- logic/reg_req_decode.sv
/* Request decode stage
   Registers an accepted request with its word address and range check */

module reg_req_decode (
    input  logic                           core_clk_ifc,
    input  logic                           interconnect_sreset_core,

    // Request channel in
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic                           req_write,
    input  router_reg_map_pkg::byte_addr_t req_addr,
    input  router_reg_map_pkg::reg_word_t  req_wdata,

    // Decoded request out
    output logic                           d_valid,
    input  logic                           d_ready,
    output logic                           d_write,
    output router_reg_map_pkg::word_addr_t d_addr,
    output router_reg_map_pkg::reg_word_t  d_wdata,
    output logic                           d_known
);

    router_reg_map_pkg::word_addr_t word_addr;
    logic                           in_range;
    logic                           req_take;

    assign word_addr = router_reg_map_pkg::word_addr_t'(req_addr >> 2); // Drop byte offset
    assign in_range  = word_addr < router_reg_map_pkg::word_addr_t'(router_reg_map_pkg::NUM_REGS);

    // Empty, or contents leave this cycle
    assign req_ready = !d_valid || d_ready;
    assign req_take  = req_valid && req_ready;

    // Stage valid
    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            d_valid <= 1'b0;
        end else if (req_ready) begin
            d_valid <= req_valid;
        end
    end

    // Payload, loaded only on a transfer
    always_ff @(posedge core_clk_ifc) begin
        if (req_take) begin
            d_write <= req_write;
            d_addr  <= word_addr;
            d_wdata <= req_wdata;
            d_known <= in_range; // Out of range flagged once here
        end
    end

endmodule

//--- logic/ctrl_reg_file.sv
/* Control register file stage
   Holds the writable registers, applies writes and forms read words */

module ctrl_reg_file #(
    parameter int NUM_ING_PORTS = 4,
    parameter int MTU_BYTES     = 2000
) (
    input  logic                           core_clk_ifc,
    input  logic                           interconnect_sreset_core,

    // From decode
    input  logic                           d_valid,
    output logic                           d_ready,
    input  logic                           d_write,
    input  router_reg_map_pkg::word_addr_t d_addr,
    input  router_reg_map_pkg::reg_word_t  d_wdata,
    input  logic                           d_known,

    // To response stage
    output logic                           f_valid,
    input  logic                           f_ready,
    output logic                           f_write,
    output logic                           f_error,
    output router_reg_map_pkg::reg_word_t  f_rdata,

    // Port control and status
    output logic [NUM_ING_PORTS-1:0]       ing_ports_enable,
    input  logic [NUM_ING_PORTS-1:0]       ing_ports_connected,

    // Counter bank sideband
    output logic [NUM_ING_PORTS-1:0]       sample_con,
    output router_cntr_pkg::port_sel_t     port_sel,
    output router_cntr_pkg::cntr_sel_t     cntr_sel,
    input  router_reg_map_pkg::reg_word_t  sel_cnt
);

    ////////////////////
    // PARAMS0 constant

    localparam logic [15:0] MTU_VEC   = 16'(MTU_BYTES);
    localparam logic [7:0]  PORTS_VEC = 8'(NUM_ING_PORTS);
    localparam router_reg_map_pkg::reg_word_t PARAMS_WORD =
        (router_reg_map_pkg::reg_word_t'(MTU_VEC) << router_reg_map_pkg::PARAMS_MTU_LSB) |
        (router_reg_map_pkg::reg_word_t'(PORTS_VEC) << router_reg_map_pkg::PARAMS_NUM_PORTS_LSB);

    logic                          d_take;
    logic                          wr_en;
    logic [NUM_ING_PORTS-1:0]      enable_stat;
    router_reg_map_pkg::reg_word_t rd_word;

    assign d_ready = !f_valid || f_ready;
    assign d_take  = d_valid && d_ready;
    assign wr_en   = d_take && d_write && d_known;

    // Read word for the current address, zero extended fields
    always_comb begin
        case (d_addr)
            router_reg_map_pkg::ADDR_PARAMS0:              rd_word = PARAMS_WORD;
            router_reg_map_pkg::ADDR_ING_PORT_ENABLE_CON:  rd_word = 32'(ing_ports_enable);
            router_reg_map_pkg::ADDR_ING_PORT_ENABLE_STAT: rd_word = 32'(enable_stat);
            router_reg_map_pkg::ADDR_ING_CNTR_SAMPLE_CON:  rd_word = 32'(sample_con);
            router_reg_map_pkg::ADDR_ING_CNTR_READ_SEL: begin
                rd_word = (32'(port_sel) << router_reg_map_pkg::SEL_PORT_LSB) |
                          (32'(cntr_sel) << router_reg_map_pkg::SEL_CNTR_LSB);
            end
            router_reg_map_pkg::ADDR_ING_CNTR_READ_DATA:   rd_word = sel_cnt; // Sampled count
            default:                                       rd_word = '0;
        endcase
    end

    ////////////////////
    // Control registers

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            ing_ports_enable <= '1; // All ports on
            sample_con       <= '0;
            port_sel         <= '0;
            cntr_sel         <= '0;
            enable_stat      <= '0;
        end else begin
            enable_stat <= ing_ports_connected; // One cycle behind the inputs
            if (wr_en) begin
                case (d_addr)
                    router_reg_map_pkg::ADDR_ING_PORT_ENABLE_CON: begin
                        ing_ports_enable <= d_wdata[NUM_ING_PORTS-1:0];
                    end
                    router_reg_map_pkg::ADDR_ING_CNTR_SAMPLE_CON: begin
                        sample_con <= d_wdata[NUM_ING_PORTS-1:0];
                    end
                    router_reg_map_pkg::ADDR_ING_CNTR_READ_SEL: begin
                        port_sel <= d_wdata[router_reg_map_pkg::SEL_PORT_LSB +: 8];
                        cntr_sel <= d_wdata[router_reg_map_pkg::SEL_CNTR_LSB +: 8];
                    end
                    default: begin
                        // Read only words keep their value, OK response
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Stage register

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            f_valid <= 1'b0;
        end else if (d_ready) begin
            f_valid <= d_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (d_take) begin
            f_write <= d_write;
            f_error <= !d_known; // Unknown word
            f_rdata <= rd_word;
        end
    end

endmodule

//--- logic/ing_cntr_sample_bank.sv
/* Ingress counter sample bank
   Counts overflow events, samples all counters per port and drives clears */

module ing_cntr_sample_bank #(
    parameter int NUM_ING_PORTS = 4,
    parameter int CNTR_WIDTH    = 32
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  interconnect_sreset_core,

    // From the register file
    input  logic [NUM_ING_PORTS-1:0]              sample_con,
    input  router_cntr_pkg::port_sel_t            port_sel,
    input  router_cntr_pkg::cntr_sel_t            cntr_sel,
    output router_reg_map_pkg::reg_word_t         sel_cnt,

    // Port counters, port p in bits p*CNTR_WIDTH up
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0]   ing_pkt_cnt,
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0]   ing_byte_cnt,
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0]   ing_err_cnt,

    // Overflow events
    input  logic [NUM_ING_PORTS-1:0]              ing_async_fifo_overflow,
    input  logic [NUM_ING_PORTS-1:0]              ing_buf_overflow,
    output logic [NUM_ING_PORTS-1:0]              ing_cnts_clear
);

    localparam int NUM_CNTRS = router_cntr_pkg::NUM_CNTRS_PER_PORT;

    logic [NUM_ING_PORTS-1:0] sample_d;
    logic [NUM_ING_PORTS-1:0] fifo_ovf_d;
    logic [NUM_ING_PORTS-1:0] buf_ovf_d;
    logic [NUM_ING_PORTS-1:0] sample_rise;
    logic [NUM_ING_PORTS-1:0] fifo_ovf_rise;
    logic [NUM_ING_PORTS-1:0] buf_ovf_rise;

    logic [CNTR_WIDTH-1:0] fifo_ovf_cnt [NUM_ING_PORTS];
    logic [CNTR_WIDTH-1:0] buf_ovf_cnt  [NUM_ING_PORTS];
    logic [CNTR_WIDTH-1:0] sampled      [NUM_ING_PORTS][NUM_CNTRS];

    // Rising edge detect
    assign sample_rise   = sample_con & ~sample_d;
    assign fifo_ovf_rise = ing_async_fifo_overflow & ~fifo_ovf_d;
    assign buf_ovf_rise  = ing_buf_overflow & ~buf_ovf_d;

    ////////////////////
    // Counting and capture

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            sample_d       <= '0;
            fifo_ovf_d     <= '0;
            buf_ovf_d      <= '0;
            ing_cnts_clear <= '0;
            for (int p = 0; p < NUM_ING_PORTS; p++) begin
                fifo_ovf_cnt[p] <= '0;
                buf_ovf_cnt[p]  <= '0;
                for (int c = 0; c < NUM_CNTRS; c++) begin
                    sampled[p][c] <= '0;
                end
            end
        end else begin
            sample_d       <= sample_con;
            fifo_ovf_d     <= ing_async_fifo_overflow;
            buf_ovf_d      <= ing_buf_overflow;
            ing_cnts_clear <= sample_rise; // Single cycle pulse
            for (int p = 0; p < NUM_ING_PORTS; p++) begin
                if (sample_rise[p]) begin
                    sampled[p][router_cntr_pkg::CNTR_PKT]  <= ing_pkt_cnt[p*CNTR_WIDTH +: CNTR_WIDTH];
                    sampled[p][router_cntr_pkg::CNTR_BYTE] <= ing_byte_cnt[p*CNTR_WIDTH +: CNTR_WIDTH];
                    sampled[p][router_cntr_pkg::CNTR_ERR]  <= ing_err_cnt[p*CNTR_WIDTH +: CNTR_WIDTH];
                    sampled[p][router_cntr_pkg::CNTR_FIFO_OVF] <= fifo_ovf_cnt[p];
                    sampled[p][router_cntr_pkg::CNTR_BUF_OVF]  <= buf_ovf_cnt[p];
                    fifo_ovf_cnt[p] <= '0; // Coincident event dropped
                    buf_ovf_cnt[p]  <= '0;
                end else begin
                    if (fifo_ovf_rise[p]) begin
                        fifo_ovf_cnt[p] <= fifo_ovf_cnt[p] + 1'b1; // Wraps
                    end
                    if (buf_ovf_rise[p]) begin
                        buf_ovf_cnt[p] <= buf_ovf_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Read select mux

    // No match leaves zero, covers out of range selectors
    always_comb begin
        sel_cnt = '0;
        for (int p = 0; p < NUM_ING_PORTS; p++) begin
            for (int c = 0; c < NUM_CNTRS; c++) begin
                if (port_sel == 8'(p) && cntr_sel == 8'(c)) begin
                    sel_cnt = 32'(sampled[p][c]);
                end
            end
        end
    end

endmodule

//--- logic/reg_resp_stage.sv
/* Response output stage
   Holds each response stable until taken */

module reg_resp_stage (
    input  logic                          core_clk_ifc,
    input  logic                          interconnect_sreset_core,

    // From register file
    input  logic                          f_valid,
    output logic                          f_ready,
    input  logic                          f_write,
    input  logic                          f_error,
    input  router_reg_map_pkg::reg_word_t f_rdata,

    // Response channel out
    output logic                          rsp_valid,
    input  logic                          rsp_ready,
    output logic                          rsp_write,
    output logic                          rsp_error,
    output router_reg_map_pkg::reg_word_t rsp_rdata
);

    logic f_take;

    assign f_ready = !rsp_valid || rsp_ready; // Free or draining
    assign f_take  = f_valid && f_ready;

    always_ff @(posedge core_clk_ifc) begin
        if (interconnect_sreset_core) begin
            rsp_valid <= 1'b0;
        end else if (f_ready) begin
            rsp_valid <= f_valid;
        end
    end

    // Payload, no data on writes and errors
    always_ff @(posedge core_clk_ifc) begin
        if (f_take) begin
            rsp_write <= f_write;
            rsp_error <= f_error;
            rsp_rdata <= (f_write || f_error) ? '0 : f_rdata;
        end
    end

endmodule

//--- logic/p4_router_ing_regs.sv
/* Ingress control register block of the packet router
   Decode, register file and response stages around the counter bank */

module p4_router_ing_regs #(
    parameter int NUM_ING_PORTS = 4,
    parameter int CNTR_WIDTH    = 32,
    parameter int MTU_BYTES     = 2000
) (
    input  logic                                core_clk_ifc,
    input  logic                                interconnect_sreset_core,

    // Request channel
    input  logic                                req_valid,
    output logic                                req_ready,
    input  logic                                req_write,
    input  router_reg_map_pkg::byte_addr_t      req_addr,
    input  router_reg_map_pkg::reg_word_t       req_wdata,

    // Response channel
    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic                                rsp_write,
    output logic                                rsp_error,
    output router_reg_map_pkg::reg_word_t       rsp_rdata,

    // Ingress ports
    output logic [NUM_ING_PORTS-1:0]            ing_ports_enable,
    input  logic [NUM_ING_PORTS-1:0]            ing_ports_connected,
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0] ing_pkt_cnt,
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0] ing_byte_cnt,
    input  logic [NUM_ING_PORTS*CNTR_WIDTH-1:0] ing_err_cnt,
    input  logic [NUM_ING_PORTS-1:0]            ing_async_fifo_overflow,
    input  logic [NUM_ING_PORTS-1:0]            ing_buf_overflow,
    output logic [NUM_ING_PORTS-1:0]            ing_cnts_clear
);

    // Decode to register file
    logic                           d_valid;
    logic                           d_ready;
    logic                           d_write;
    router_reg_map_pkg::word_addr_t d_addr;
    router_reg_map_pkg::reg_word_t  d_wdata;
    logic                           d_known;

    // Register file to response
    logic                           f_valid;
    logic                           f_ready;
    logic                           f_write;
    logic                           f_error;
    router_reg_map_pkg::reg_word_t  f_rdata;

    // Counter sideband
    logic [NUM_ING_PORTS-1:0]       sample_con;
    router_cntr_pkg::port_sel_t     port_sel;
    router_cntr_pkg::cntr_sel_t     cntr_sel;
    router_reg_map_pkg::reg_word_t  sel_cnt;

    reg_req_decode u_decode (
        .core_clk_ifc, .interconnect_sreset_core,
        .req_valid, .req_ready, .req_write, .req_addr, .req_wdata,
        .d_valid, .d_ready, .d_write, .d_addr, .d_wdata, .d_known
    );

    ctrl_reg_file #(.NUM_ING_PORTS(NUM_ING_PORTS), .MTU_BYTES(MTU_BYTES)) u_reg_file (
        .core_clk_ifc, .interconnect_sreset_core,
        .d_valid, .d_ready, .d_write, .d_addr, .d_wdata, .d_known,
        .f_valid, .f_ready, .f_write, .f_error, .f_rdata,
        .ing_ports_enable, .ing_ports_connected,
        .sample_con, .port_sel, .cntr_sel, .sel_cnt
    );

    ing_cntr_sample_bank #(.NUM_ING_PORTS(NUM_ING_PORTS), .CNTR_WIDTH(CNTR_WIDTH)) u_cntr_bank (
        .core_clk_ifc, .interconnect_sreset_core,
        .sample_con, .port_sel, .cntr_sel, .sel_cnt,
        .ing_pkt_cnt, .ing_byte_cnt, .ing_err_cnt,
        .ing_async_fifo_overflow, .ing_buf_overflow, .ing_cnts_clear
    );

    reg_resp_stage u_resp (
        .core_clk_ifc, .interconnect_sreset_core,
        .f_valid, .f_ready, .f_write, .f_error, .f_rdata,
        .rsp_valid, .rsp_ready, .rsp_write, .rsp_error, .rsp_rdata
    );

endmodule

//--- verif/p4_router_ing_regs_tb.sv
/* Testbench for the ingress control register block
   Shadow model of the register map, in-order response checks, back-pressure */

module p4_router_ing_regs_tb;

    localparam int NUM_PORTS = 4;
    localparam int CW        = 32;
    localparam int MTU       = 2000;
    localparam int TIMEOUT   = 200; // Cycles allowed per wait

    // Byte addresses of the register words
    localparam logic [15:0] BA_PARAMS0     = 16'h0000;
    localparam logic [15:0] BA_ENABLE_CON  = 16'h0004;
    localparam logic [15:0] BA_ENABLE_STAT = 16'h0008;
    localparam logic [15:0] BA_SAMPLE_CON  = 16'h000C;
    localparam logic [15:0] BA_READ_SEL    = 16'h0010;
    localparam logic [15:0] BA_READ_DATA   = 16'h0014;

    logic                      core_clk_ifc = 1'b0;
    logic                      interconnect_sreset_core;
    logic                      req_valid;
    logic                      req_ready;
    logic                      req_write;
    logic [15:0]               req_addr;
    logic [31:0]               req_wdata;
    logic                      rsp_valid;
    logic                      rsp_ready = 1'b1;
    logic                      rsp_write;
    logic                      rsp_error;
    logic [31:0]               rsp_rdata;
    logic [NUM_PORTS-1:0]      ing_ports_enable;
    logic [NUM_PORTS-1:0]      ing_ports_connected;
    logic [NUM_PORTS*CW-1:0]   ing_pkt_cnt;
    logic [NUM_PORTS*CW-1:0]   ing_byte_cnt;
    logic [NUM_PORTS*CW-1:0]   ing_err_cnt;
    logic [NUM_PORTS-1:0]      ing_async_fifo_overflow;
    logic [NUM_PORTS-1:0]      ing_buf_overflow;
    logic [NUM_PORTS-1:0]      ing_cnts_clear;

    ////////////////////
    // Shadow state

    logic [NUM_PORTS-1:0] en_sh;
    logic [NUM_PORTS-1:0] conn_sh;
    logic [NUM_PORTS-1:0] samp_con_sh;
    logic [7:0]           sel_port_sh;
    logic [7:0]           sel_cntr_sh;
    logic [31:0]          fifo_cnt_sh [NUM_PORTS]; // Pulses since last sample
    logic [31:0]          buf_cnt_sh  [NUM_PORTS];
    logic [31:0]          samp_sh     [NUM_PORTS][5];
    int                   exp_clears  [NUM_PORTS];
    int                   clear_seen  [NUM_PORTS];

    logic [33:0] exp_q [$];  // {write, error, rdata}
    logic [15:0] lfsr;
    logic [15:0] bp_lfsr;    // Separate stream for rsp_ready
    logic        bp_on;
    int          checks;
    int          value_errors;
    int          other_errors;

    p4_router_ing_regs DUT (.*);

    always #50 core_clk_ifc = ~core_clk_ifc;

    // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr); // One step per bit
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Expected read word of a register word address
    function automatic logic [31:0] expected_read(input int waddr);
        int port;
        int cntr;
        port = int'(sel_port_sh);
        cntr = int'(sel_cntr_sh);
        case (waddr)
            0: return {8'd0, 8'(NUM_PORTS), 16'(MTU)};
            1: return 32'(en_sh);
            2: return 32'(conn_sh);
            3: return 32'(samp_con_sh);
            4: return {16'd0, sel_port_sh, sel_cntr_sh};
            5: return (port < NUM_PORTS && cntr < 5) ? samp_sh[port][cntr] : 32'h0;
            default: return 32'h0;
        endcase
    endfunction

    // Write effect on the shadow with sample capture on a rising SAMPLE_CON bit
    function automatic void update_shadow(input int waddr, input logic [31:0] wdata);
        logic [NUM_PORTS-1:0] rise;
        case (waddr)
            1: en_sh = wdata[NUM_PORTS-1:0];
            3: begin
                rise        = wdata[NUM_PORTS-1:0] & ~samp_con_sh;
                samp_con_sh = wdata[NUM_PORTS-1:0];
                for (int p = 0; p < NUM_PORTS; p++) begin
                    if (rise[p]) begin
                        samp_sh[p][0]  = ing_pkt_cnt[p*CW +: CW];
                        samp_sh[p][1]  = ing_byte_cnt[p*CW +: CW];
                        samp_sh[p][2]  = ing_err_cnt[p*CW +: CW];
                        samp_sh[p][3]  = fifo_cnt_sh[p];
                        samp_sh[p][4]  = buf_cnt_sh[p];
                        fifo_cnt_sh[p] = '0;
                        buf_cnt_sh[p]  = '0;
                        exp_clears[p]++; // One clear cycle each
                    end
                end
            end
            4: begin
                sel_port_sh = wdata[15:8];
                sel_cntr_sh = wdata[7:0];
            end
            default: ; // Read only words unchanged
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        other_errors++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        $display("Test failures found");
        $finish;
    endtask

    ////////////////////
    // Request side

    task automatic send_request(input logic write, input logic [15:0] addr,
                                input logic [31:0] wdata);
        int          waddr;
        logic        err;
        logic [31:0] rdata;
        logic        taken;
        int          cycles;
        waddr = int'(addr >> 2);
        err   = (waddr >= 6);
        rdata = (write || err) ? 32'h0 : expected_read(waddr);
        exp_q.push_back({write, err, rdata});
        if (write && !err) begin
            update_shadow(waddr, wdata);
        end
        @(negedge core_clk_ifc);
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        taken     = 1'b0;
        cycles    = 0;
        while (!taken) begin
            @(posedge core_clk_ifc);
            taken = req_ready; // Transfer at this edge
            cycles++;
            if (!taken && cycles > TIMEOUT) begin
                abort_on_timeout("request acceptance");
            end
        end
    endtask

    task automatic wait_responses();
        int cycles;
        @(negedge core_clk_ifc);
        req_valid = 1'b0;
        cycles    = 0;
        while (exp_q.size() != 0) begin
            @(negedge core_clk_ifc);
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_on_timeout("outstanding responses");
            end
        end
    endtask

    task automatic reg_access(input logic write, input logic [15:0] addr,
                              input logic [31:0] wdata);
        send_request(write, addr, wdata);
        wait_responses();
    endtask

    task automatic read_counter(input int port, input int cntr);
        reg_access(1'b1, BA_READ_SEL, {16'd0, 8'(port), 8'(cntr)});
        reg_access(1'b0, BA_READ_DATA, 32'h0);
    endtask

    // Separated pulses on one port's overflow inputs
    task automatic pulse_overflow(input int port, input int fifo_n, input int buf_n);
        for (int i = 0; i < fifo_n || i < buf_n; i++) begin
            @(negedge core_clk_ifc);
            ing_async_fifo_overflow[port] = (i < fifo_n);
            ing_buf_overflow[port]        = (i < buf_n);
            @(negedge core_clk_ifc);
            ing_async_fifo_overflow = '0;
            ing_buf_overflow        = '0;
        end
        fifo_cnt_sh[port] = fifo_cnt_sh[port] + 32'(fifo_n);
        buf_cnt_sh[port]  = buf_cnt_sh[port] + 32'(buf_n);
    endtask

    task automatic check_clears();
        repeat (2) @(negedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_value($sformatf("ing_cnts_clear[%0d] high cycles", p),
                        32'(exp_clears[p]), 32'(clear_seen[p]));
        end
    endtask

    ////////////////////
    // Monitors

    // In-order response compare
    always @(posedge core_clk_ifc) begin
        logic [33:0] exp_rsp;
        if (!interconnect_sreset_core && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("At %0t a response arrived with no request outstanding", $time);
            end else begin
                exp_rsp = exp_q.pop_front();
                check_value("rsp_write", 32'(exp_rsp[33]), 32'(rsp_write));
                check_value("rsp_error", 32'(exp_rsp[32]), 32'(rsp_error));
                check_value("rsp_rdata", exp_rsp[31:0], rsp_rdata);
            end
        end
    end

    always @(posedge core_clk_ifc) begin
        if (!interconnect_sreset_core) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (ing_cnts_clear[p]) begin
                    clear_seen[p]++;
                end
            end
        end
    end

    always @(negedge core_clk_ifc) begin
        if (bp_on) begin
            bp_lfsr   = lfsr_next(bp_lfsr);
            rsp_ready = bp_lfsr[0]; // Random stall
        end else begin
            rsp_ready = 1'b1;
        end
    end

    ////////////////////
    // Test sequence

    initial begin
        logic [2:0]  kind;
        logic [31:0] data;
        interconnect_sreset_core = 1'b1;
        req_valid               = 1'b0;
        req_write               = 1'b0;
        req_addr                = '0;
        req_wdata               = '0;
        ing_ports_connected     = '0;
        ing_pkt_cnt             = '0;
        ing_byte_cnt            = '0;
        ing_err_cnt             = '0;
        ing_async_fifo_overflow = '0;
        ing_buf_overflow        = '0;
        en_sh       = '1;
        conn_sh     = '0;
        samp_con_sh = '0;
        sel_port_sh = '0;
        sel_cntr_sh = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            fifo_cnt_sh[p] = '0;
            buf_cnt_sh[p]  = '0;
            exp_clears[p]  = 0;
            clear_seen[p]  = 0;
            for (int c = 0; c < 5; c++) begin
                samp_sh[p][c] = '0;
            end
        end
        lfsr         = 16'd12;
        bp_lfsr      = 16'd12;
        bp_on        = 1'b0;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        repeat (2) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        interconnect_sreset_core = 1'b0;

        // Reset values
        check_value("ing_ports_enable", 32'((1 << NUM_PORTS) - 1), 32'(ing_ports_enable));
        check_value("ing_cnts_clear", 32'h0, 32'(ing_cnts_clear));
        reg_access(1'b0, BA_PARAMS0, 32'h0);
        reg_access(1'b0, BA_ENABLE_CON, 32'h0);
        reg_access(1'b0, BA_SAMPLE_CON, 32'h0);
        reg_access(1'b0, BA_READ_SEL, 32'h0);

        // Writes and readback then writes to read only words
        reg_access(1'b1, BA_ENABLE_CON, rand_bits(32));
        check_value("ing_ports_enable", 32'(en_sh), 32'(ing_ports_enable));
        reg_access(1'b0, BA_ENABLE_CON, 32'h0);
        reg_access(1'b1, BA_SAMPLE_CON, rand_bits(32));
        reg_access(1'b0, BA_SAMPLE_CON, 32'h0);
        reg_access(1'b1, BA_READ_SEL, rand_bits(32));
        reg_access(1'b0, BA_READ_SEL, 32'h0);
        reg_access(1'b1, BA_PARAMS0, rand_bits(32));
        reg_access(1'b0, BA_PARAMS0, 32'h0);
        reg_access(1'b1, BA_ENABLE_STAT, rand_bits(32));
        reg_access(1'b0, BA_ENABLE_STAT, 32'h0);
        check_clears();

        // Unknown words
        reg_access(1'b0, 16'h0018, 32'h0);
        reg_access(1'b1, 16'h001C, rand_bits(32));
        reg_access(1'b0, 16'hFFFC, 32'h0);
        reg_access(1'b0, BA_PARAMS0, 32'h0);

        // Enable status follows the connected inputs
        for (int i = 0; i < 2; i++) begin
            @(negedge core_clk_ifc);
            ing_ports_connected = 4'(rand_bits(4));
            conn_sh             = ing_ports_connected;
            repeat (2) @(negedge core_clk_ifc);
            reg_access(1'b0, BA_ENABLE_STAT, 32'h0);
        end

        // Counter sampling
        @(negedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            ing_pkt_cnt[p*CW +: CW]  = rand_bits(32);
            ing_byte_cnt[p*CW +: CW] = rand_bits(32);
            ing_err_cnt[p*CW +: CW]  = rand_bits(32);
        end
        pulse_overflow(2, 3, 5);
        pulse_overflow(1, 2, 1);
        reg_access(1'b1, BA_SAMPLE_CON, 32'h0);
        reg_access(1'b1, BA_SAMPLE_CON, 32'h4); // Port 2 only
        check_clears();
        for (int c = 0; c < 5; c++) begin
            read_counter(2, c);
        end
        reg_access(1'b1, BA_SAMPLE_CON, 32'h0);
        reg_access(1'b1, BA_SAMPLE_CON, 32'h4); // No new pulses
        check_clears();
        read_counter(2, 3);
        read_counter(2, 4);
        reg_access(1'b1, BA_SAMPLE_CON, 32'h2);
        check_clears();
        for (int c = 0; c < 5; c++) begin
            read_counter(1, c);
        end
        read_counter(9, 0);
        read_counter(1, 7); // Port holds nonzero samples

        // Mixed stream under random rsp_ready stalls
        bp_on = 1'b1;
        for (int i = 0; i < 40; i++) begin
            kind = 3'(rand_bits(3));
            data = rand_bits(32);
            case (kind)
                3'd0, 3'd1: send_request(1'b0, {11'd0, 3'(rand_bits(3)), 2'b00}, 32'h0);
                3'd2: send_request(1'b1, BA_ENABLE_CON, data);
                3'd3: send_request(1'b1, BA_READ_SEL, {21'd0, data[10:8], 5'd0, data[2:0]});
                3'd4: send_request(1'b1, data[0] ? BA_PARAMS0 : BA_ENABLE_STAT, data);
                3'd5: send_request(1'b1, data[0] ? 16'h0018 : 16'h001C, data);
                default: send_request(1'b0, BA_READ_DATA, 32'h0);
            endcase
        end
        wait_responses();
        bp_on = 1'b0;
        check_value("ing_ports_enable", 32'(en_sh), 32'(ing_ports_enable));

        repeat (2) @(negedge core_clk_ifc);
        $display("Checks: %0d, value errors: %0d, other errors: %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
logic/router_reg_map_pkg.sv
logic/router_cntr_pkg.sv
logic/reg_req_decode.sv
logic/ctrl_reg_file.sv
logic/ing_cntr_sample_bank.sv
logic/reg_resp_stage.sv
logic/p4_router_ing_regs.sv
verif/p4_router_ing_regs_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the ingress register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module p4_router_ing_regs_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vp4_router_ing_regs_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
